// ==== frame_filter.f ====
source/frame_filter_pkg.sv
source/axis_if.sv
source/frame_len_check.sv
source/frame_fifo.sv
source/frame_stats.sv
source/frame_filter.sv
verif/frame_filter_tb.sv

// ==== source/axis_if.sv ====
`timescale 1ns/1ps

interface axis_if;

  frame_filter_pkg::data_t tdata;
  frame_filter_pkg::keep_t tkeep;
  logic                    tlast;
  logic                    tuser; // bad frame
  logic                    tvalid;
  logic                    tready;

  modport src (
    output tdata, tkeep, tlast, tuser, tvalid,
    input  tready
  );

  modport snk (
    input  tdata, tkeep, tlast, tuser, tvalid,
    output tready
  );

endinterface

// ==== source/frame_fifo.sv ====
`timescale 1ns/1ps

module frame_fifo (
  input  logic                    clk,
  input  logic                    rst,
  axis_if.snk                     s,
  output frame_filter_pkg::data_t m_tdata,
  output frame_filter_pkg::keep_t m_tkeep,
  output logic                    m_tlast,
  output logic                    m_tvalid,
  input  logic                    m_tready,
  output logic                    good_frame,
  output logic                    bad_frame,
  output logic                    overflow
);

  // memory split by field
  frame_filter_pkg::data_t mem_data [2**frame_filter_pkg::FIFO_ADDR_WIDTH];
  frame_filter_pkg::keep_t mem_keep [2**frame_filter_pkg::FIFO_ADDR_WIDTH];
  logic                    mem_last [2**frame_filter_pkg::FIFO_ADDR_WIDTH];

  // extra msb tells full from empty
  logic [frame_filter_pkg::FIFO_ADDR_WIDTH:0] wr_ptr;     // committed
  logic [frame_filter_pkg::FIFO_ADDR_WIDTH:0] wr_ptr_cur; // speculative
  logic [frame_filter_pkg::FIFO_ADDR_WIDTH:0] rd_ptr;

  logic full_cur;
  logic empty;
  logic accept;
  logic write;
  logic read;
  logic store_output;
  logic drop_frame;

  frame_filter_pkg::data_t rd_data;
  frame_filter_pkg::keep_t rd_keep;
  logic                    rd_last;
  logic                    rd_valid;

  frame_filter_pkg::data_t out_data;
  frame_filter_pkg::keep_t out_keep;
  logic                    out_last;
  logic                    out_valid;

  logic good_reg;
  logic bad_reg;
  logic overflow_reg;

  assign full_cur =
    (wr_ptr_cur[frame_filter_pkg::FIFO_ADDR_WIDTH] != rd_ptr[frame_filter_pkg::FIFO_ADDR_WIDTH]) &&
    (wr_ptr_cur[frame_filter_pkg::FIFO_ADDR_WIDTH-1:0] ==
     rd_ptr[frame_filter_pkg::FIFO_ADDR_WIDTH-1:0]);
  assign empty = wr_ptr == rd_ptr;

  assign s.tready = 1'b1; // never stalls, drops on overflow instead
  assign accept   = s.tvalid;
  assign write    = accept && !full_cur && !drop_frame;

  // write side
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr       <= '0;
      wr_ptr_cur   <= '0;
      drop_frame   <= 1'b0;
      good_reg     <= 1'b0;
      bad_reg      <= 1'b0;
      overflow_reg <= 1'b0;
    end else begin
      good_reg     <= 1'b0;
      bad_reg      <= 1'b0;
      overflow_reg <= 1'b0;
      if (accept) begin
        if (full_cur || drop_frame) begin
          drop_frame <= 1'b1;
          if (s.tlast) begin
            wr_ptr_cur   <= wr_ptr; // roll back whole frame
            drop_frame   <= 1'b0;
            overflow_reg <= 1'b1;
          end
        end else if (s.tlast) begin
          if (s.tuser) begin
            wr_ptr_cur <= wr_ptr;
            bad_reg    <= 1'b1;
          end else begin
            wr_ptr     <= wr_ptr_cur + 1'b1; // commit
            wr_ptr_cur <= wr_ptr_cur + 1'b1;
            good_reg   <= 1'b1;
          end
        end else begin
          wr_ptr_cur <= wr_ptr_cur + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (write) begin
      mem_data[wr_ptr_cur[frame_filter_pkg::FIFO_ADDR_WIDTH-1:0]] <= s.tdata;
      mem_keep[wr_ptr_cur[frame_filter_pkg::FIFO_ADDR_WIDTH-1:0]] <= s.tkeep;
      mem_last[wr_ptr_cur[frame_filter_pkg::FIFO_ADDR_WIDTH-1:0]] <= s.tlast;
    end
  end

  // read side, memory register then output register
  assign store_output = m_tready || !out_valid;
  assign read         = (store_output || !rd_valid) && !empty;

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr    <= '0;
      rd_valid  <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      if (read) begin
        rd_ptr   <= rd_ptr + 1'b1;
        rd_valid <= 1'b1;
      end else if (store_output) begin
        rd_valid <= 1'b0;
      end
      if (store_output) begin
        out_valid <= rd_valid;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (read) begin
      rd_data <= mem_data[rd_ptr[frame_filter_pkg::FIFO_ADDR_WIDTH-1:0]];
      rd_keep <= mem_keep[rd_ptr[frame_filter_pkg::FIFO_ADDR_WIDTH-1:0]];
      rd_last <= mem_last[rd_ptr[frame_filter_pkg::FIFO_ADDR_WIDTH-1:0]];
    end
    if (store_output) begin
      out_data <= rd_data;
      out_keep <= rd_keep;
      out_last <= rd_last;
    end
  end

  assign m_tdata    = out_data;
  assign m_tkeep    = out_keep;
  assign m_tlast    = out_last;
  assign m_tvalid   = out_valid;
  assign good_frame = good_reg;
  assign bad_frame  = bad_reg;
  assign overflow   = overflow_reg;

endmodule

// ==== source/frame_filter.sv ====
`timescale 1ns/1ps

module frame_filter (
  input  logic                         clk,
  input  logic                         rst,
  input  frame_filter_pkg::data_t      s_tdata,
  input  frame_filter_pkg::keep_t      s_tkeep,
  input  logic                         s_tlast,
  input  logic                         s_tuser,
  input  logic                         s_tvalid,
  output logic                         s_tready,
  output frame_filter_pkg::data_t      m_tdata,
  output frame_filter_pkg::keep_t      m_tkeep,
  output logic                         m_tlast,
  output logic                         m_tvalid,
  input  logic                         m_tready,
  output frame_filter_pkg::frame_cnt_t good_frames,
  output frame_filter_pkg::frame_cnt_t bad_frames,
  output frame_filter_pkg::frame_cnt_t overflow_frames
);

  axis_if s_axis ();
  axis_if chk_to_fifo ();

  logic good_frame;
  logic bad_frame;
  logic overflow;

  // top-level input onto the checker's stream
  assign s_axis.tdata  = s_tdata;
  assign s_axis.tkeep  = s_tkeep;
  assign s_axis.tlast  = s_tlast;
  assign s_axis.tuser  = s_tuser;
  assign s_axis.tvalid = s_tvalid;
  assign s_tready      = s_axis.tready;

  frame_len_check u_len_check (
    .clk (clk),
    .rst (rst),
    .s   (s_axis.snk),
    .m   (chk_to_fifo.src)
  );

  frame_fifo u_fifo (
    .clk        (clk),
    .rst        (rst),
    .s          (chk_to_fifo.snk),
    .m_tdata    (m_tdata),
    .m_tkeep    (m_tkeep),
    .m_tlast    (m_tlast),
    .m_tvalid   (m_tvalid),
    .m_tready   (m_tready),
    .good_frame (good_frame),
    .bad_frame  (bad_frame),
    .overflow   (overflow)
  );

  frame_stats u_stats (
    .clk             (clk),
    .rst             (rst),
    .good_frame      (good_frame),
    .bad_frame       (bad_frame),
    .overflow        (overflow),
    .good_frames     (good_frames),
    .bad_frames      (bad_frames),
    .overflow_frames (overflow_frames)
  );

endmodule

// ==== source/frame_filter_pkg.sv ====
package frame_filter_pkg;

  // stream beat payload and byte enables
  typedef logic [31:0] data_t;
  typedef logic [3:0]  keep_t;

  // frame FIFO memory, 32 entries
  localparam int FIFO_ADDR_WIDTH = 5;

  // beats seen in a frame, saturates at all ones
  typedef logic [4:0] beat_cnt_t;

  // good frame length limits in beats
  localparam int MIN_FRAME_BEATS = 2;
  localparam int MAX_FRAME_BEATS = 16;

  typedef logic [15:0] frame_cnt_t; // saturating statistics

endpackage

// ==== source/frame_len_check.sv ====
`timescale 1ns/1ps

module frame_len_check (
  input  logic clk,
  input  logic rst,
  axis_if.snk  s,
  axis_if.src  m
);

  frame_filter_pkg::data_t     data_reg;
  frame_filter_pkg::keep_t     keep_reg;
  logic                        last_reg;
  logic                        user_reg;
  logic                        valid_reg;
  frame_filter_pkg::beat_cnt_t beat_cnt; // beats before the current one
  logic                        err_sticky;
  logic                        accept;
  logic                        too_short;
  logic                        too_long;
  logic                        frame_bad;

  assign s.tready = !valid_reg || m.tready;
  assign accept   = s.tvalid && s.tready;

  // frame length is beat_cnt + 1 on the last beat
  assign too_short = beat_cnt < (frame_filter_pkg::MIN_FRAME_BEATS - 1);
  assign too_long  = beat_cnt > (frame_filter_pkg::MAX_FRAME_BEATS - 1);
  assign frame_bad = err_sticky || s.tuser || too_short || too_long;

  assign m.tdata  = data_reg;
  assign m.tkeep  = keep_reg;
  assign m.tlast  = last_reg;
  assign m.tuser  = user_reg;
  assign m.tvalid = valid_reg;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_reg  <= 1'b0;
      beat_cnt   <= '0;
      err_sticky <= 1'b0;
    end else begin
      if (accept) begin
        valid_reg <= 1'b1;
      end else if (m.tready) begin
        valid_reg <= 1'b0;
      end

      if (accept) begin
        if (s.tlast) begin
          beat_cnt   <= '0;
          err_sticky <= 1'b0;
        end else begin
          if (beat_cnt != '1) begin
            beat_cnt <= beat_cnt + 1'b1; // saturate
          end
          err_sticky <= err_sticky || s.tuser;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      data_reg <= s.tdata;
      keep_reg <= s.tkeep;
      last_reg <= s.tlast;
      // verdict only lands on the last beat
      user_reg <= s.tlast ? frame_bad : s.tuser;
    end
  end

endmodule

// ==== source/frame_stats.sv ====
`timescale 1ns/1ps

module frame_stats (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         good_frame,
  input  logic                         bad_frame,
  input  logic                         overflow,
  output frame_filter_pkg::frame_cnt_t good_frames,
  output frame_filter_pkg::frame_cnt_t bad_frames,
  output frame_filter_pkg::frame_cnt_t overflow_frames
);

  frame_filter_pkg::frame_cnt_t good_cnt;
  frame_filter_pkg::frame_cnt_t bad_cnt;
  frame_filter_pkg::frame_cnt_t ovf_cnt;

  // holds at all ones
  function automatic frame_filter_pkg::frame_cnt_t sat_inc(
    input frame_filter_pkg::frame_cnt_t value
  );
    if (value == '1) begin
      return value;
    end
    return value + 1'b1;
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      good_cnt <= '0;
      bad_cnt  <= '0;
      ovf_cnt  <= '0;
    end else begin
      if (good_frame) good_cnt <= sat_inc(good_cnt);
      if (bad_frame) bad_cnt <= sat_inc(bad_cnt);
      if (overflow) ovf_cnt <= sat_inc(ovf_cnt);
    end
  end

  assign good_frames     = good_cnt;
  assign bad_frames      = bad_cnt;
  assign overflow_frames = ovf_cnt;

endmodule

// ==== verif/frame_filter_tb.sv ====
`timescale 1ns/1ps

module frame_filter_tb;

  localparam int RANDOM_FRAMES = 40;

  logic                         clk = 1'b0;
  logic                         rst;
  frame_filter_pkg::data_t      s_tdata;
  frame_filter_pkg::keep_t      s_tkeep;
  logic                         s_tlast;
  logic                         s_tuser;
  logic                         s_tvalid;
  logic                         s_tready;
  frame_filter_pkg::data_t      m_tdata;
  frame_filter_pkg::keep_t      m_tkeep;
  logic                         m_tlast;
  logic                         m_tvalid;
  logic                         m_tready;
  frame_filter_pkg::frame_cnt_t good_frames;
  frame_filter_pkg::frame_cnt_t bad_frames;
  frame_filter_pkg::frame_cnt_t overflow_frames;

  integer      seed = 32'hed43;
  bit          rand_ready = 1'b0;
  logic [36:0] sent_beats[$]; // {last, keep, data}
  int          sent_len[$];
  bit          sent_good[$];
  logic [36:0] exp_beats[$];  // committed and not yet out
  int          beats_sent = 0;
  int          frames_sent = 0;
  int          frames_delivered = 0;
  int          cycles = 0;
  logic [36:0] out_prev;
  bit          hold_prev = 1'b0;
  frame_filter_pkg::frame_cnt_t good_prev = '0;
  frame_filter_pkg::frame_cnt_t bad_prev = '0;
  frame_filter_pkg::frame_cnt_t ovf_prev = '0;

  frame_filter u_dut (.*);

  always #5 clk = ~clk;

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic next_cycle();
    @(negedge clk);
    if (rand_ready) m_tready = ($random(seed) & 3) != 0; // ready about 3 of 4 cycles
  endtask

  // one frame with no tuser beat when err_at is negative
  task automatic send_frame(input int len, input int err_at, input bit gaps);
    logic [31:0] rnd;
    bit          good;
    good = len >= frame_filter_pkg::MIN_FRAME_BEATS &&
           len <= frame_filter_pkg::MAX_FRAME_BEATS && err_at < 0;
    for (int i = 0; i < len; i++) begin
      while (gaps && ($random(seed) & 3) == 0) begin
        s_tvalid = 1'b0;
        next_cycle();
      end
      rnd = $random(seed);
      s_tdata = rnd;
      rnd = $random(seed);
      s_tkeep = rnd[3:0];
      s_tlast = i == len - 1;
      s_tuser = i == err_at;
      s_tvalid = 1'b1;
      sent_beats.push_back({s_tlast, s_tkeep, s_tdata});
      beats_sent++;
      while (!s_tready) next_cycle();
      next_cycle(); // beat taken on the edge in between
    end
    s_tvalid = 1'b0;
    s_tlast = 1'b0;
    s_tuser = 1'b0;
    sent_len.push_back(len);
    sent_good.push_back(good);
    frames_sent++;
  endtask

  task automatic drain();
    while (sent_len.size() != 0 || exp_beats.size() != 0) next_cycle();
    repeat (2) next_cycle();
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles > beats_sent * 20 + 500) abort_run("timeout, the DUT stopped making progress");
  end

  // m_ must hold while stalled
  always @(posedge clk) begin
    if (!rst && hold_prev) begin
      assert (m_tvalid && {m_tlast, m_tkeep, m_tdata} == out_prev) else
        abort_run($sformatf(
          "** Error: m_ beat under stall, m_tvalid %h {tlast,tkeep,tdata} %h was %h",
          m_tvalid, {m_tlast, m_tkeep, m_tdata}, out_prev));
    end
    hold_prev = !rst && m_tvalid && !m_tready;
    out_prev = {m_tlast, m_tkeep, m_tdata};
  end

  always @(posedge clk) begin
    logic [36:0] exp;
    if (!rst && m_tvalid && m_tready) begin
      if (exp_beats.size() == 0) begin
        abort_run("a beat came out on m_ that belongs to no committed frame");
      end else begin
        exp = exp_beats.pop_front();
        assert (m_tdata == exp[31:0]) else
          abort_run($sformatf("** Error: m_tdata got %h expected %h", m_tdata, exp[31:0]));
        assert (m_tkeep == exp[35:32]) else
          abort_run($sformatf("** Error: m_tkeep got %h expected %h", m_tkeep, exp[35:32]));
        assert (m_tlast == exp[36]) else
          abort_run($sformatf("** Error: m_tlast got %h expected %h", m_tlast, exp[36]));
        if (m_tlast) frames_delivered++;
      end
    end
  end

  // each counter step settles the oldest outstanding frame
  always @(negedge clk) begin
    int dg;
    int db;
    int dov;
    int len;
    bit good;
    if (!rst) begin
      assert (s_tready) else abort_run("s_tready went low after reset");
      dg = int'(good_frames) - int'(good_prev);
      db = int'(bad_frames) - int'(bad_prev);
      dov = int'(overflow_frames) - int'(ovf_prev);
      if (dg != 0 || db != 0 || dov != 0) begin
        assert (dg >= 0 && db >= 0 && dov >= 0 && dg + db + dov == 1) else
          abort_run($sformatf("** Error: step good_frames %h bad_frames %h overflow_frames %h",
                              good_frames, bad_frames, overflow_frames));
        assert (sent_len.size() != 0) else
          abort_run("a frame counter moved with no frame pending");
        len = sent_len.pop_front();
        good = sent_good.pop_front();
        assert (dg == 0 || good) else
          abort_run("a frame breaking the length or error rule was counted good");
        assert (db == 0 || !good) else abort_run("a good frame was counted as bad");
        for (int i = 0; i < len; i++) begin
          if (dg == 1) exp_beats.push_back(sent_beats.pop_front());
          else void'(sent_beats.pop_front());
        end
      end
    end
    good_prev = good_frames;
    bad_prev = bad_frames;
    ovf_prev = overflow_frames;
  end

  initial begin
    logic [31:0] r;
    int          len;
    int          err_at;
    int          good_exp;
    int          bad_exp;
    int          base_sent;
    int          base_del;
    rst = 1'b1;
    s_tdata = '0;
    s_tkeep = '0;
    s_tlast = 1'b0;
    s_tuser = 1'b0;
    s_tvalid = 1'b0;
    m_tready = 1'b1;
    good_exp = 0;
    bad_exp = 0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    next_cycle();
    assert (m_tvalid == 1'b0) else
      abort_run($sformatf("** Error: m_tvalid got %h expected 0 after reset", m_tvalid));
    assert (good_frames == '0 && bad_frames == '0 && overflow_frames == '0) else
      abort_run($sformatf("** Error: good_frames %h bad_frames %h overflow_frames %h expected 0",
                          good_frames, bad_frames, overflow_frames));

    // good frames with the output always ready
    for (int f = 0; f < 10; f++) begin
      r = $random(seed);
      send_frame(2 + int'(r[3:0]) % 15, -1, 1'b0);
      good_exp++;
      repeat (3) next_cycle();
      assert (int'(good_frames) == good_exp) else
        abort_run($sformatf("** Error: good_frames got %h expected %h", good_frames, good_exp));
    end

    // tuser frames then too short and too long ones
    for (int f = 0; f < 8; f++) begin
      r = $random(seed);
      len = (f < 4) ? 2 + int'(r[3:0]) % 15 : (f < 6) ? 1 : 17 + int'(r[2:0]);
      err_at = (f < 4) ? int'(r[7:4]) % len : -1;
      send_frame(len, err_at, 1'b0);
      bad_exp++;
      repeat (3) next_cycle();
      assert (int'(bad_frames) == bad_exp) else
        abort_run($sformatf("** Error: bad_frames got %h expected %h", bad_frames, bad_exp));
    end
    drain();

    // fill until a frame overflows
    m_tready = 1'b0;
    base_sent = frames_sent;
    base_del = frames_delivered;
    for (int f = 0; f < 6 && overflow_frames == '0; f++) begin
      send_frame(frame_filter_pkg::MAX_FRAME_BEATS, -1, 1'b0);
      repeat (3) next_cycle();
    end
    assert (overflow_frames != '0) else
      abort_run("overflow_frames never rose with m_tready held low");
    m_tready = 1'b1;
    drain();
    assert (frames_delivered - base_del + int'(overflow_frames) == frames_sent - base_sent) else
      abort_run($sformatf("** Error: delivered plus overflow_frames %h expected %h",
                          frames_delivered - base_del + int'(overflow_frames),
                          frames_sent - base_sent));

    // mixed random traffic
    rand_ready = 1'b1;
    for (int f = 0; f < RANDOM_FRAMES; f++) begin
      r = $random(seed);
      len = 1 + int'(r[4:0]) % 20;
      err_at = (r[7:5] == 3'd0) ? int'(r[11:8]) % len : -1;
      send_frame(len, err_at, 1'b1);
    end
    rand_ready = 1'b0;
    m_tready = 1'b1;
    drain();
    assert (int'(good_frames) + int'(bad_frames) + int'(overflow_frames) == frames_sent) else
      abort_run($sformatf("** Error: counter sum %h expected %h",
                          int'(good_frames) + int'(bad_frames) + int'(overflow_frames),
                          frames_sent));
    $display("RESULT: PASS");
    $finish;
  end

endmodule
